//--- cpu_settings.svh
/* CPU settings
   Data and address widths, opcodes and reset values for the accumulator core */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_WIDTH 16
`define ADDR_WIDTH 8
`define INS_WIDTH  8

`define PC_RESET   8'h00      // Program starts at ROM word 0
`define AC_RESET   16'h0000

// Opcodes, one ROM word each
`define OP_ASSIGN  8'h70      // Low 2 bits pick C1, C2 or C3
`define OP_LOAD_C1 8'h52
`define OP_LOAD_C2 8'h53
`define OP_STORE   8'h60
`define OP_RESET   8'h80
`define OP_MOVE_P  8'h90
`define OP_MOVE_T  8'h91
`define OP_SET_C1  8'hA0
`define OP_SET_DR  8'hA1
`define OP_MUL_P   8'hB0
`define OP_ADD_T   8'hC0
`define OP_INC_C2  8'hD0
`define OP_INC_C3  8'hD1
`define OP_HALT    8'hFF

`endif

//--- cpuPkg.sv
/* CPU types
   Sequencer states, bus sources, write masks, ALU operations and the ROM word */
`default_nettype none

`include "cpu_settings.svh"

package cpuPkg;

    typedef enum logic [4:0] {
        SeqIdle    = 5'h00,
        SeqFetch1  = 5'h01,
        SeqFetch2  = 5'h02,
        SeqExec    = 5'h03,   // First execute state, dispatches on IR
        SeqAssign2 = 5'h04,
        SeqAssign3 = 5'h05,
        SeqLoad2   = 5'h06,
        SeqLoad3   = 5'h07,
        SeqStore2  = 5'h08,
        SeqStore3  = 5'h09,
        SeqHalt    = 5'h1F
    } seqState_e;

    typedef enum logic [2:0] {
        BusNone,
        BusRom,    // Immediate byte from the ROM
        BusDr,
        BusT,
        BusP,
        BusC1,     // C1, or C2 when cSel picks it
        BusC3,
        BusAc
    } busSrc_e;

    // Write enables, C3 reached through cSel
    typedef struct packed {
        logic pc;
        logic ir;
        logic ar;
        logic dr;
        logic p;
        logic t;
        logic c1;
        logic c2;
    } regMask_t;

    typedef enum logic [1:0] {
        AluNone,
        AluSet,
        AluMul,
        AluAdd
    } aluOp_e;

    typedef struct packed {
        logic [`INS_WIDTH/2-1:0] group;
        logic [`INS_WIDTH/2-1:0] variant;
    } opcode_t;

    // Same ROM word seen as an opcode or as an immediate address
    typedef union packed {
        opcode_t                op;
        logic [`ADDR_WIDTH-1:0] imm;
    } insWord_u;

endpackage

`default_nettype wire

//--- opcodeSequencer.sv
/* Opcode sequencer
   Fetch and execute state machine that issues all datapath and memory strobes */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module opcodeSequencer (
    input  logic             Clk,
    input  logic             rstN,
    input  cpuPkg::insWord_u ir,
    output logic             insRead,
    output logic             memRead,
    output logic             memWrite,
    output logic             halted,
    output cpuPkg::regMask_t regWrite,
    output logic [1:0]       cSel,
    output cpuPkg::busSrc_e  busSel,
    output logic             pcInc,
    output logic             c2Inc,
    output logic             c3Inc,
    output logic             clearAll,
    output logic             acWrite,
    output cpuPkg::aluOp_e   aluOp
);
    localparam logic [7:0] AssignOp = `OP_ASSIGN;

    cpuPkg::seqState_e state;
    cpuPkg::seqState_e nextState;
    logic              isAssign;

    // Only variants 0..2 of the ASSIGN group name a register
    assign isAssign = (ir.op.group == AssignOp[7:4]) && (ir.op.variant < 4'd3);

    // C register select, shared by ASSIGN, LOAD and SET C1
    always_comb begin
        if (ir.imm == `OP_LOAD_C1 || ir.imm == `OP_LOAD_C2) begin
            cSel = {1'b0, ir.op.variant[0]};
        end else begin
            cSel = ir.op.variant[1:0];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= cpuPkg::SeqIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = cpuPkg::SeqFetch1;
        insRead   = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        halted    = 1'b0;
        regWrite  = '0;
        busSel    = cpuPkg::BusNone;
        pcInc     = 1'b0;
        c2Inc     = 1'b0;
        c3Inc     = 1'b0;
        clearAll  = 1'b0;
        acWrite   = 1'b0;
        aluOp     = cpuPkg::AluNone;
        case (state)
            cpuPkg::SeqFetch1: begin
                insRead   = 1'b1;
                nextState = cpuPkg::SeqFetch2;
            end
            cpuPkg::SeqFetch2: begin
                regWrite.ir = 1'b1;
                pcInc       = 1'b1;
                nextState   = cpuPkg::SeqExec;
            end
            cpuPkg::SeqExec: begin
                if (isAssign) begin
                    insRead   = 1'b1;           // Immediate sits at PC
                    nextState = cpuPkg::SeqAssign2;
                end else begin
                    case (ir.imm)
                        `OP_LOAD_C1, `OP_LOAD_C2: begin
                            busSel      = cpuPkg::BusC1;
                            regWrite.ar = 1'b1;
                            nextState   = cpuPkg::SeqLoad2;
                        end
                        `OP_STORE: begin
                            busSel      = cpuPkg::BusT;
                            regWrite.dr = 1'b1;
                            nextState   = cpuPkg::SeqStore2;
                        end
                        `OP_RESET:  clearAll = 1'b1;
                        `OP_MOVE_P: begin
                            busSel     = cpuPkg::BusAc;
                            regWrite.p = 1'b1;
                        end
                        `OP_MOVE_T: begin
                            busSel     = cpuPkg::BusAc;
                            regWrite.t = 1'b1;
                        end
                        `OP_SET_C1, `OP_SET_DR, `OP_MUL_P, `OP_ADD_T: begin
                            acWrite = 1'b1;
                            case (ir.imm)
                                `OP_SET_C1: busSel = cpuPkg::BusC1;
                                `OP_SET_DR: busSel = cpuPkg::BusDr;
                                `OP_MUL_P:  busSel = cpuPkg::BusP;
                                default:    busSel = cpuPkg::BusT;
                            endcase
                            case (ir.imm)
                                `OP_MUL_P: aluOp = cpuPkg::AluMul;
                                `OP_ADD_T: aluOp = cpuPkg::AluAdd;
                                default:   aluOp = cpuPkg::AluSet;
                            endcase
                        end
                        `OP_INC_C2: c2Inc = 1'b1;
                        `OP_INC_C3: c3Inc = 1'b1;
                        `OP_HALT:   nextState = cpuPkg::SeqHalt;
                        default: ;                  // NO_OP
                    endcase
                end
            end
            cpuPkg::SeqAssign2: begin
                busSel      = cpuPkg::BusRom;
                regWrite.ar = 1'b1;
                pcInc       = 1'b1;
                nextState   = cpuPkg::SeqAssign3;
            end
            cpuPkg::SeqAssign3: begin
                regWrite.c1 = (cSel == 2'd0);
                regWrite.c2 = (cSel != 2'd0);   // C2 or C3
            end
            cpuPkg::SeqLoad2: begin
                memRead   = 1'b1;
                nextState = cpuPkg::SeqLoad3;
            end
            cpuPkg::SeqLoad3: begin
                busSel      = cpuPkg::BusDr;    // DR reloads from memory
                regWrite.dr = 1'b1;
            end
            cpuPkg::SeqStore2: begin
                busSel      = cpuPkg::BusC3;
                regWrite.ar = 1'b1;
                nextState   = cpuPkg::SeqStore3;
            end
            cpuPkg::SeqStore3: memWrite = 1'b1;
            cpuPkg::SeqHalt: begin
                halted    = 1'b1;
                nextState = cpuPkg::SeqHalt;
            end
            default: ;                          // Idle falls into fetch
        endcase
    end

    // Memory port is single-ported
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(memRead && memWrite));

endmodule

`default_nettype wire

//--- datapathRegs.sv
/* Datapath register bank
   PC, IR, AR, DR, P, T and the C registers around one shared bus */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module datapathRegs (
    input  logic                   Clk,
    input  logic                   rstN,
    input  cpuPkg::insWord_u       insData,
    input  logic [`DATA_WIDTH-1:0] memRData,
    input  logic [`DATA_WIDTH-1:0] acValue,
    input  cpuPkg::regMask_t       regWrite,
    input  logic [1:0]             cSel,
    input  cpuPkg::busSrc_e        busSel,
    input  logic                   pcInc,
    input  logic                   c2Inc,
    input  logic                   c3Inc,
    input  logic                   clearAll,
    output logic [`ADDR_WIDTH-1:0] insAddr,
    output logic [`ADDR_WIDTH-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0] memWData,
    output cpuPkg::insWord_u       ir,
    output logic [`DATA_WIDTH-1:0] busValue
);
    localparam int PadWidth = `DATA_WIDTH - `ADDR_WIDTH;

    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ADDR_WIDTH-1:0] ar;
    logic [`ADDR_WIDTH-1:0] c1;
    logic [`ADDR_WIDTH-1:0] c2;
    logic [`ADDR_WIDTH-1:0] c3;
    logic [`DATA_WIDTH-1:0] dr;
    logic [`DATA_WIDTH-1:0] p;
    logic [`DATA_WIDTH-1:0] t;
    logic                   cWrite;

    assign insAddr  = pc;
    assign memAddr  = ar;
    assign memWData = dr;
    assign cWrite   = regWrite.c1 | regWrite.c2;

    // Shared bus, addresses zero-extended
    always_comb begin
        case (busSel)
            cpuPkg::BusRom: busValue = {{PadWidth{1'b0}}, insData.imm};
            cpuPkg::BusDr:  busValue = dr;
            cpuPkg::BusT:   busValue = t;
            cpuPkg::BusP:   busValue = p;
            cpuPkg::BusC1:  busValue = {{PadWidth{1'b0}}, (cSel == 2'd1) ? c2 : c1};
            cpuPkg::BusC3:  busValue = {{PadWidth{1'b0}}, c3};
            cpuPkg::BusAc:  busValue = acValue;
            default:        busValue = '0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= `PC_RESET;
            ir <= '0;
        end else begin
            if (regWrite.pc) begin
                pc <= busValue[`ADDR_WIDTH-1:0];
            end else if (pcInc) begin
                pc <= pc + 1'b1;
            end
            if (regWrite.ir) ir <= insData;
        end
    end

    always_ff @(posedge Clk) begin
        if (regWrite.ar) ar <= busValue[`ADDR_WIDTH-1:0];
        if (regWrite.dr) begin
            // DR source slot means the memory return word
            dr <= (busSel == cpuPkg::BusDr) ? memRData : busValue;
        end
        if (regWrite.p) p <= busValue;
        if (clearAll) begin
            t <= '0;
        end else if (regWrite.t) begin
            t <= busValue;
        end
        // C registers load from AR, cSel 0/1/2 = C1/C2/C3
        if (cWrite && cSel == 2'd0) c1 <= ar;
        if (c2Inc) begin
            c2 <= c2 + 1'b1;
        end else if (cWrite && cSel == 2'd1) begin
            c2 <= ar;
        end
        if (c3Inc) begin
            c3 <= c3 + 1'b1;
        end else if (cWrite && cSel == 2'd2) begin
            c3 <= ar;
        end
    end

    // Every bus-fed register write needs a real source
    busDriven: assert property (@(posedge Clk) disable iff (!rstN)
        (regWrite.ar || regWrite.dr || regWrite.p || regWrite.t)
            |-> busSel != cpuPkg::BusNone);

endmodule

`default_nettype wire

//--- accumulatorAlu.sv
/* Accumulator ALU
   AC register with set, multiply and add from the shared bus */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module accumulatorAlu (
    input  logic                   Clk,
    input  logic                   rstN,
    input  cpuPkg::aluOp_e         aluOp,
    input  logic                   acWrite,
    input  logic                   clearAll,
    input  logic [`DATA_WIDTH-1:0] busValue,
    output logic [`DATA_WIDTH-1:0] acValue
);
    logic [2*`DATA_WIDTH-1:0] product;

    assign product = busValue * acValue;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            acValue <= `AC_RESET;
        end else if (clearAll) begin
            acValue <= '0;
        end else if (acWrite) begin
            case (aluOp)
                cpuPkg::AluSet: acValue <= busValue;
                cpuPkg::AluMul: acValue <= product[`DATA_WIDTH-1:0];   // Low half only
                cpuPkg::AluAdd: acValue <= busValue + acValue;
                default:        acValue <= acValue;
            endcase
        end
    end

    // Sequencer always pairs acWrite with an operation
    aluOpValid: assert property (@(posedge Clk) disable iff (!rstN)
        acWrite |-> aluOp != cpuPkg::AluNone);

endmodule

`default_nettype wire

//--- cpuCore.sv
/* CPU core
   Accumulator processor top, sequencer plus register bank plus ALU */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpuCore (
    input  logic                   Clk,
    input  logic                   rstN,
    input  cpuPkg::insWord_u       insData,
    input  logic [`DATA_WIDTH-1:0] memRData,
    output logic                   insRead,
    output logic [`ADDR_WIDTH-1:0] insAddr,
    output logic                   memRead,
    output logic                   memWrite,
    output logic [`ADDR_WIDTH-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0] memWData,
    output logic                   halted
);
    cpuPkg::insWord_u       ir;
    cpuPkg::regMask_t       regWrite;
    cpuPkg::busSrc_e        busSel;
    cpuPkg::aluOp_e         aluOp;
    logic [1:0]             cSel;
    logic                   pcInc;
    logic                   c2Inc;
    logic                   c3Inc;
    logic                   clearAll;
    logic                   acWrite;
    logic [`DATA_WIDTH-1:0] busValue;
    logic [`DATA_WIDTH-1:0] acValue;

    opcodeSequencer i_opcodeSequencer (
        .Clk      (Clk),
        .rstN     (rstN),
        .ir       (ir),
        .insRead  (insRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted),
        .regWrite (regWrite),
        .cSel     (cSel),
        .busSel   (busSel),
        .pcInc    (pcInc),
        .c2Inc    (c2Inc),
        .c3Inc    (c3Inc),
        .clearAll (clearAll),
        .acWrite  (acWrite),
        .aluOp    (aluOp)
    );

    datapathRegs i_datapathRegs (
        .Clk      (Clk),
        .rstN     (rstN),
        .insData  (insData),
        .memRData (memRData),
        .acValue  (acValue),
        .regWrite (regWrite),
        .cSel     (cSel),
        .busSel   (busSel),
        .pcInc    (pcInc),
        .c2Inc    (c2Inc),
        .c3Inc    (c3Inc),
        .clearAll (clearAll),
        .insAddr  (insAddr),
        .memAddr  (memAddr),
        .memWData (memWData),
        .ir       (ir),
        .busValue (busValue)
    );

    accumulatorAlu i_accumulatorAlu (
        .Clk      (Clk),
        .rstN     (rstN),
        .aluOp    (aluOp),
        .acWrite  (acWrite),
        .clearAll (clearAll),
        .busValue (busValue),
        .acValue  (acValue)
    );

endmodule

`default_nettype wire

//--- cpuCoreTb.sv
/* CPU core testbench
   Runs a multiply and add program against ROM and data memory models */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpuCoreTb;
    localparam int MemDepth    = 2**`ADDR_WIDTH;
    localparam int HaltTimeout = 500;   // Cycles

    logic                   Clk;
    logic                   rstN;
    logic [`INS_WIDTH-1:0]  insData = '0;
    logic [`DATA_WIDTH-1:0] memRData = '0;
    logic                   insRead;
    logic [`ADDR_WIDTH-1:0] insAddr;
    logic                   memRead;
    logic                   memWrite;
    logic [`ADDR_WIDTH-1:0] memAddr;
    logic [`DATA_WIDTH-1:0] memWData;
    logic                   halted;

    logic [`INS_WIDTH-1:0]  rom [0:MemDepth-1];
    logic [`DATA_WIDTH-1:0] mem [0:MemDepth-1];
    int                     progLen;
    integer                 seed;
    int                     waitCycles;

    // Pending requests of the two synchronous memories
    logic                   insPending = 1'b0;
    logic [`ADDR_WIDTH-1:0] insPendAddr = '0;
    logic                   memPending = 1'b0;
    logic [`ADDR_WIDTH-1:0] memPendAddr = '0;

    logic [`ADDR_WIDTH-1:0] nextFetchAddr = `PC_RESET;
    logic [`ADDR_WIDTH-1:0] fetchExpected = `PC_RESET;
    logic [`ADDR_WIDTH-1:0] expReadAddr [0:1];
    logic [`ADDR_WIDTH-1:0] expWriteAddr [0:2];
    logic [`DATA_WIDTH-1:0] expWriteData [0:2];
    logic [`ADDR_WIDTH-1:0] readExpected = '0;
    logic [`ADDR_WIDTH-1:0] writeAddrExpected = '0;
    logic [`DATA_WIDTH-1:0] writeDataExpected = '0;
    int                     readCount = 0;
    int                     writeCount = 0;

    cpuCore i_cpuCore (
        .Clk      (Clk),
        .rstN     (rstN),
        .insData  (insData),
        .memRData (memRData),
        .insRead  (insRead),
        .insAddr  (insAddr),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWData (memWData),
        .halted   (halted)
    );

    always #2 Clk = ~Clk;

    task automatic failMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic failCheck(input string what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    task automatic appendWord(input logic [`INS_WIDTH-1:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < MemDepth; i++) begin
            rom[i] = `OP_HALT;              // Runaway code stops here
        end
        progLen = 0;
        appendWord(`OP_ASSIGN);             // C1 = 0x10
        appendWord(8'h10);
        appendWord(`OP_ASSIGN + 8'd1);      // C2 = 0x11
        appendWord(8'h11);
        appendWord(`OP_ASSIGN + 8'd2);      // C3 = 0x20
        appendWord(8'h20);
        appendWord(`OP_LOAD_C1);
        appendWord(`OP_SET_DR);
        appendWord(`OP_MOVE_P);             // P = mem[C1]
        appendWord(`OP_LOAD_C2);
        appendWord(`OP_SET_DR);
        appendWord(`OP_MUL_P);
        appendWord(`OP_MOVE_T);             // T = product
        appendWord(`OP_STORE);
        appendWord(`OP_INC_C3);
        appendWord(`OP_ADD_T);
        appendWord(`OP_MOVE_T);             // T = twice the product
        appendWord(`OP_STORE);
        appendWord(`OP_RESET);
        appendWord(`OP_INC_C3);
        appendWord(`OP_STORE);              // Cleared T
        appendWord(`OP_HALT);
    endtask

    // Random data words and the expected access list
    task automatic fillDataMemory();
        int                     i;
        logic [31:0]            word;
        logic [`DATA_WIDTH-1:0] product;
        seed = 96;
        for (i = 0; i < MemDepth; i++) begin
            word   = $random(seed);
            mem[i] = word[`DATA_WIDTH-1:0];
        end
        product = mem[8'h10] * mem[8'h11];  // Low 16 bits only
        expReadAddr[0]  = 8'h10;
        expReadAddr[1]  = 8'h11;
        expWriteAddr[0] = 8'h20;
        expWriteAddr[1] = 8'h21;
        expWriteAddr[2] = 8'h22;
        expWriteData[0] = product;
        expWriteData[1] = product + product;
        expWriteData[2] = '0;
    endtask

    // Memory models and expected values on the falling edge
    always @(negedge Clk) begin
        if (insPending) insData <= rom[insPendAddr];
        if (memPending) memRData <= mem[memPendAddr];
        insPending  <= rstN && insRead;
        insPendAddr <= insAddr;
        memPending  <= rstN && memRead;
        memPendAddr <= memAddr;
        if (rstN && insRead) begin
            fetchExpected <= nextFetchAddr;
            nextFetchAddr <= nextFetchAddr + 1'b1;
        end
        if (rstN && memRead) begin
            if (readCount < 2) readExpected <= expReadAddr[readCount];
            readCount <= readCount + 1;
        end
        if (rstN && memWrite) begin
            mem[memAddr] <= memWData;
            if (writeCount < 3) begin
                writeAddrExpected <= expWriteAddr[writeCount];
                writeDataExpected <= expWriteData[writeCount];
            end
            writeCount <= writeCount + 1;
        end
    end

    quietAfterReset: assert property (@(posedge Clk)
        $rose(rstN) |-> {insRead, memRead, memWrite, halted} == 4'b0000)
        else failMismatch("strobes", 0, $sampled({insRead, memRead, memWrite, halted}));

    fetchOrder: assert property (@(posedge Clk) disable iff (!rstN)
        insRead |-> insAddr == fetchExpected)
        else failMismatch("insAddr", $sampled(fetchExpected), $sampled(insAddr));

    readAddress: assert property (@(posedge Clk) disable iff (!rstN)
        memRead |-> memAddr == readExpected)
        else failMismatch("memAddr", $sampled(readExpected), $sampled(memAddr));

    readLimit: assert property (@(posedge Clk) disable iff (!rstN)
        memRead |-> readCount <= 2)
        else failCheck("more memory reads than the program issues");

    writeAddress: assert property (@(posedge Clk) disable iff (!rstN)
        memWrite |-> memAddr == writeAddrExpected)
        else failMismatch("memAddr", $sampled(writeAddrExpected), $sampled(memAddr));

    writeData: assert property (@(posedge Clk) disable iff (!rstN)
        memWrite |-> memWData == writeDataExpected)
        else failMismatch("memWData", $sampled(writeDataExpected), $sampled(memWData));

    writeLimit: assert property (@(posedge Clk) disable iff (!rstN)
        memWrite |-> writeCount <= 3)
        else failCheck("more memory writes than the program issues");

    haltQuiet: assert property (@(posedge Clk) disable iff (!rstN)
        halted |-> !insRead && !memRead && !memWrite)
        else failCheck("fetch or memory access after halt");

    haltSticky: assert property (@(posedge Clk) disable iff (!rstN)
        $past(halted) |-> halted)
        else failCheck("halted dropped without a reset");

    initial begin
        Clk  = 1'b0;
        rstN = 1'b0;
        loadProgram();
        fillDataMemory();
        repeat (2) @(negedge Clk);
        rstN       = 1'b1;
        waitCycles = 0;
        while (!halted && waitCycles < HaltTimeout) begin
            @(negedge Clk);
            waitCycles++;
        end
        if (!halted) begin
            failCheck("timeout while waiting for halted");
        end else begin
            repeat (4) @(negedge Clk);      // Core must stay idle
            allReads: assert (readCount == 2)
                else failMismatch("readCount", 2, readCount);
            allWrites: assert (writeCount == 3)
                else failMismatch("writeCount", 3, writeCount);
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cpuPkg.sv
opcodeSequencer.sv
datapathRegs.sv
accumulatorAlu.sv
cpuCore.sv
cpuCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module cpuCoreTb -o cpuCoreSim \
    && ./obj_dir/cpuCoreSim \
    || { echo "simulation did not pass"; exit 1; }
